//--- src/perf_pkg.sv
// performance monitor types, counter indices and register map shared by all blocks.
`default_nettype none

package perf_pkg;

	localparam int CSR_ADDR_W = 4;
	localparam int CSR_DATA_W = 32;
	localparam int NUM_COUNTERS = 9;

	localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_ENABLE = 4'd12; // group enable mask.
	localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CLEAR = 4'd13;  // write clears all counters.

	// raw status strobes straight from the pipeline and the caches.
	typedef struct packed {
		logic if_stall;
		logic resp_l2;
		logic flush;
		logic jb_sel;
		logic l1i_miss_sig;
		logic read_a;
		logic l1d_miss_sig;
		logic read_b;
		logic write_b;
		logic l2_miss_sig;
		logic read_l2;
		logic write_l2;
		logic read_i;
		logic read_d;
		logic write_d;
	} perf_raw_t;

	typedef struct packed {
		logic br_miss;
		logic br_total;
		logic l1i_miss;
		logic l1i_total;
		logic l1d_miss;
		logic l1d_total;
		logic l2_miss;
		logic l2_total;
		logic id_conflict;
	} perf_event_t;

	typedef struct packed {
		logic branch;
		logic l1i;
		logic l1d;
		logic l2;
		logic conflict;
	} perf_group_en_t;

	typedef enum logic [3:0] {
		IDX_BR_MISS     = 4'd0,
		IDX_BR_TOTAL    = 4'd1,
		IDX_L1I_MISS    = 4'd2,
		IDX_L1I_TOTAL   = 4'd3,
		IDX_L1D_MISS    = 4'd4,
		IDX_L1D_TOTAL   = 4'd5,
		IDX_L2_MISS     = 4'd6,
		IDX_L2_TOTAL    = 4'd7,
		IDX_ID_CONFLICT = 4'd8
	} perf_idx_e;

endpackage : perf_pkg

`default_nettype wire

//--- src/perf_event_decode.sv
// event decode: registers the raw strobes and forms qualified one-cycle event pulses.
`timescale 1ns/1ps
`default_nettype none

module perf_event_decode
	import perf_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  perf_raw_t   raw,
	output perf_event_t events
);

	perf_raw_t raw_q;  // raw strobes, one cycle late.
	logic flush_prev;  // flush level of the cycle before raw_q.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			raw_q <= '0;
			flush_prev <= 1'b0;
		end
		else
		begin
			raw_q <= raw;
			flush_prev <= raw_q.flush;
		end
	end

	// a held flush is one mispredict, so only its rising edge counts.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			events <= '0;
		end
		else
		begin
			events.br_miss <= raw_q.flush & ~flush_prev;
			events.br_total <= raw_q.jb_sel & ~raw_q.if_stall;

			events.l1i_miss <= raw_q.l1i_miss_sig;
			events.l1i_total <= raw_q.read_a & ~raw_q.if_stall; // stalled fetch repeats.

			events.l1d_miss <= raw_q.l1d_miss_sig;
			events.l1d_total <= (raw_q.read_b | raw_q.write_b) & ~raw_q.if_stall;

			events.l2_miss <= raw_q.l2_miss_sig;
			events.l2_total <= (raw_q.read_l2 | raw_q.write_l2) & raw_q.resp_l2; // done only.

			// both L1 caches want the L2 port in the same cycle.
			events.id_conflict <= raw_q.read_i & (raw_q.read_d | raw_q.write_d);
		end
	end

endmodule : perf_event_decode

`default_nettype wire

//--- src/perf_counter_bank.sv
// counter bank: nine event counters with group enables, clear and the miss wrap rule.
`timescale 1ns/1ps
`default_nettype none

module perf_counter_bank
	import perf_pkg::*;
#(
	parameter int COUNT_WIDTH = 32
)
(
	input  logic                                        clk,
	input  logic                                        reset,
	input  perf_event_t                                 events,
	input  perf_group_en_t                              group_en,
	input  logic                                        clear,
	output logic [NUM_COUNTERS-1:0][COUNT_WIDTH-1:0]    counts
);

	logic [NUM_COUNTERS-1:0] hit;                             // enabled events, by index.
	logic [COUNT_WIDTH-1:0] l2_limit;                         // l2 total plus one.
	logic [NUM_COUNTERS-1:0][COUNT_WIDTH-1:0] counts_next;

	// a miss count above its paired total restarts at one.
	function automatic logic [COUNT_WIDTH-1:0] next_miss(
		input logic [COUNT_WIDTH-1:0] miss,
		input logic [COUNT_WIDTH-1:0] limit
	);
		if (miss > limit)
			return COUNT_WIDTH'(1);
		return miss + COUNT_WIDTH'(1);
	endfunction

	always_comb
	begin
		hit[IDX_BR_MISS] = events.br_miss & group_en.branch;
		hit[IDX_BR_TOTAL] = events.br_total & group_en.branch;
		hit[IDX_L1I_MISS] = events.l1i_miss & group_en.l1i;
		hit[IDX_L1I_TOTAL] = events.l1i_total & group_en.l1i;
		hit[IDX_L1D_MISS] = events.l1d_miss & group_en.l1d;
		hit[IDX_L1D_TOTAL] = events.l1d_total & group_en.l1d;
		hit[IDX_L2_MISS] = events.l2_miss & group_en.l2;
		hit[IDX_L2_TOTAL] = events.l2_total & group_en.l2;
		hit[IDX_ID_CONFLICT] = events.id_conflict & group_en.conflict;
	end

	// the l2 miss strobe runs ahead of the response the total counts.
	assign l2_limit = counts[IDX_L2_TOTAL] + COUNT_WIDTH'(1);

	always_comb
	begin
		counts_next = counts;

		if (hit[IDX_BR_MISS])
			counts_next[IDX_BR_MISS] = next_miss(counts[IDX_BR_MISS], counts[IDX_BR_TOTAL]);
		if (hit[IDX_L1I_MISS])
			counts_next[IDX_L1I_MISS] = next_miss(counts[IDX_L1I_MISS], counts[IDX_L1I_TOTAL]);
		if (hit[IDX_L1D_MISS])
			counts_next[IDX_L1D_MISS] = next_miss(counts[IDX_L1D_MISS], counts[IDX_L1D_TOTAL]);
		if (hit[IDX_L2_MISS])
			counts_next[IDX_L2_MISS] = next_miss(counts[IDX_L2_MISS], l2_limit);

		if (hit[IDX_BR_TOTAL])
			counts_next[IDX_BR_TOTAL] = counts[IDX_BR_TOTAL] + COUNT_WIDTH'(1);
		if (hit[IDX_L1I_TOTAL])
			counts_next[IDX_L1I_TOTAL] = counts[IDX_L1I_TOTAL] + COUNT_WIDTH'(1);
		if (hit[IDX_L1D_TOTAL])
			counts_next[IDX_L1D_TOTAL] = counts[IDX_L1D_TOTAL] + COUNT_WIDTH'(1);
		if (hit[IDX_L2_TOTAL])
			counts_next[IDX_L2_TOTAL] = counts[IDX_L2_TOTAL] + COUNT_WIDTH'(1);
		if (hit[IDX_ID_CONFLICT])
			counts_next[IDX_ID_CONFLICT] = counts[IDX_ID_CONFLICT] + COUNT_WIDTH'(1);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			counts <= '0;
		end
		else if (clear)
		begin
			counts <= '0; // clear beats any event this cycle.
		end
		else
		begin
			counts <= counts_next;
		end
	end

endmodule : perf_counter_bank

`default_nettype wire

//--- src/perf_csr_block.sv
// register block: enable mask, clear pulse and registered read-back of the counters.
`timescale 1ns/1ps
`default_nettype none

module perf_csr_block
	import perf_pkg::*;
#(
	parameter int COUNT_WIDTH = 32
)
(
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                        csr_wr,
	input  logic                                        csr_rd,
	input  logic [CSR_ADDR_W-1:0]                       csr_addr,
	input  logic [CSR_DATA_W-1:0]                       csr_wdata,
	output logic [CSR_DATA_W-1:0]                       csr_rdata,
	input  logic [NUM_COUNTERS-1:0][COUNT_WIDTH-1:0]    counts,
	output perf_group_en_t                              group_en,
	output logic                                        clear
);

	localparam int MASK_W = $bits(perf_group_en_t);

	logic rd_pend;                   // read accepted last cycle.
	logic [CSR_ADDR_W-1:0] rd_addr;  // address of the pending read.
	logic [CSR_DATA_W-1:0] rd_value;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			group_en <= '1; // all groups count out of reset.
			clear <= 1'b0;
		end
		else
		begin
			if (csr_wr && csr_addr == CSR_ADDR_ENABLE)
				group_en <= perf_group_en_t'(csr_wdata[MASK_W-1:0]);
			clear <= csr_wr && csr_addr == CSR_ADDR_CLEAR; // one-cycle pulse.
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_pend <= 1'b0;
		else
			rd_pend <= csr_rd;
	end

	always_ff @(posedge clk)
	begin
		if (csr_rd)
			rd_addr <= csr_addr;
	end

	// counters sit at 0..8, the mask at 12; the rest read as zero.
	always_comb
	begin
		rd_value = '0;
		if (rd_addr < CSR_ADDR_W'(NUM_COUNTERS))
			rd_value = CSR_DATA_W'(counts[rd_addr]);
		else if (rd_addr == CSR_ADDR_ENABLE)
			rd_value = CSR_DATA_W'(group_en);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			csr_rdata <= '0;
		else if (rd_pend)
			csr_rdata <= rd_value; // held until the next read.
	end

endmodule : perf_csr_block

`default_nettype wire

//--- src/perf_monitor_top.sv
// performance monitor top: event decode feeding the counter bank, read through the CSR port.
`timescale 1ns/1ps
`default_nettype none

module perf_monitor_top
	import perf_pkg::*;
#(
	parameter int COUNT_WIDTH = 32
)
(
	input  logic                    clk,
	input  logic                    reset,
	input  perf_raw_t               raw,
	input  logic                    csr_wr,
	input  logic                    csr_rd,
	input  logic [CSR_ADDR_W-1:0]   csr_addr,
	input  logic [CSR_DATA_W-1:0]   csr_wdata,
	output logic [CSR_DATA_W-1:0]   csr_rdata
);

	perf_event_t events;
	perf_group_en_t group_en;
	logic clear;
	logic [NUM_COUNTERS-1:0][COUNT_WIDTH-1:0] counts;

	perf_event_decode i_perf_event_decode (
		.clk    (clk),
		.reset  (reset),
		.raw    (raw),
		.events (events)
	);

	perf_counter_bank #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) i_perf_counter_bank (
		.clk      (clk),
		.reset    (reset),
		.events   (events),
		.group_en (group_en),
		.clear    (clear),
		.counts   (counts)
	);

	perf_csr_block #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) i_perf_csr_block (
		.clk       (clk),
		.reset     (reset),
		.csr_wr    (csr_wr),
		.csr_rd    (csr_rd),
		.csr_addr  (csr_addr),
		.csr_wdata (csr_wdata),
		.csr_rdata (csr_rdata),
		.counts    (counts),
		.group_en  (group_en),
		.clear     (clear)
	);

endmodule : perf_monitor_top

`default_nettype wire

//--- tb/perf_monitor_tb.sv
// performance monitor testbench: runs file stimulus and checks reads against a counter model.
`timescale 1ns/1ps
`default_nettype none

module perf_monitor_tb
	import perf_pkg::*;
();

	localparam int COUNT_WIDTH = 32;
	localparam int READ_LATENCY = 1;     // csr_rdata follows the read strobe by one edge.
	localparam int READ_TIMEOUT = 8;
	localparam int STIM_DEPTH = 768;     // three words per command.
	localparam int WATCHDOG_CYCLES = 5000;

	logic clk;
	logic reset;
	perf_raw_t raw;
	logic csr_wr;
	logic csr_rd;
	logic [CSR_ADDR_W-1:0] csr_addr;
	logic [CSR_DATA_W-1:0] csr_wdata;
	logic [CSR_DATA_W-1:0] csr_rdata;

	logic [31:0] stim_mem [STIM_DEPTH];
	logic [31:0] lfsr_state;
	int checks;
	int errors;
	int tests_run;

	// reference model state, stepped once per clock edge.
	logic [COUNT_WIDTH-1:0] model_counts [NUM_COUNTERS];
	perf_group_en_t model_mask;
	perf_raw_t model_raw_q;
	logic model_flush_prev;
	perf_event_t model_ev;
	logic model_clear;

	perf_monitor_top #(
		.COUNT_WIDTH (COUNT_WIDTH)
	) i_perf_monitor_top (
		.clk       (clk),
		.reset     (reset),
		.raw       (raw),
		.csr_wr    (csr_wr),
		.csr_rd    (csr_rd),
		.csr_addr  (csr_addr),
		.csr_wdata (csr_wdata),
		.csr_rdata (csr_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic perf_event_t decode_events(input perf_raw_t r, input logic flush_before);
		perf_event_t e;
		e.br_miss = r.flush & ~flush_before;
		e.br_total = r.jb_sel & ~r.if_stall;
		e.l1i_miss = r.l1i_miss_sig;
		e.l1i_total = r.read_a & ~r.if_stall;
		e.l1d_miss = r.l1d_miss_sig;
		e.l1d_total = (r.read_b | r.write_b) & ~r.if_stall;
		e.l2_miss = r.l2_miss_sig;
		e.l2_total = (r.read_l2 | r.write_l2) & r.resp_l2;
		e.id_conflict = r.read_i & (r.read_d | r.write_d);
		return e;
	endfunction

	function automatic logic [CSR_DATA_W-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr);
		if (int'(addr) < NUM_COUNTERS)
			return CSR_DATA_W'(model_counts[addr]);
		if (addr == CSR_ADDR_ENABLE)
			return CSR_DATA_W'(model_mask);
		return '0;
	endfunction

	// one clock edge of the model, using the inputs held before the edge.
	task automatic model_step();
		logic [COUNT_WIDTH-1:0] old_counts [NUM_COUNTERS];
		logic [NUM_COUNTERS-1:0] hit;
		logic [COUNT_WIDTH-1:0] limit;
		old_counts = model_counts;
		hit = {model_ev.id_conflict & model_mask.conflict,
			model_ev.l2_total & model_mask.l2, model_ev.l2_miss & model_mask.l2,
			model_ev.l1d_total & model_mask.l1d, model_ev.l1d_miss & model_mask.l1d,
			model_ev.l1i_total & model_mask.l1i, model_ev.l1i_miss & model_mask.l1i,
			model_ev.br_total & model_mask.branch, model_ev.br_miss & model_mask.branch};
		for (int i = 0; i < NUM_COUNTERS; i++)
		begin
			if (model_clear)
				model_counts[i] = '0;
			else if (hit[i])
				model_counts[i] = old_counts[i] + COUNT_WIDTH'(1);
		end
		// misses sit at even indices, each followed by its total.
		for (int i = 0; i < NUM_COUNTERS - 1; i += 2)
		begin
			limit = old_counts[i+1] + COUNT_WIDTH'(i == int'(IDX_L2_MISS));
			if (!model_clear && hit[i] && old_counts[i] > limit)
				model_counts[i] = COUNT_WIDTH'(1);
		end
		model_ev = decode_events(model_raw_q, model_flush_prev);
		model_flush_prev = model_raw_q.flush;
		model_raw_q = raw;
		model_clear = csr_wr && csr_addr == CSR_ADDR_CLEAR;
		if (csr_wr && csr_addr == CSR_ADDR_ENABLE)
			model_mask = perf_group_en_t'(csr_wdata[$bits(perf_group_en_t)-1:0]);
	endtask

	task automatic tick();
		@(posedge clk);
		model_step();
		#1; // inputs change 1 ns after the edge.
	endtask

	task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] actual,
		input logic [COUNT_WIDTH-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic check_mask(input string name, input perf_group_en_t actual,
		input perf_group_en_t expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic write_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
		raw = '0;
		csr_wr = 1'b1;
		csr_addr = addr;
		csr_wdata = data;
		tick();
		csr_wr = 1'b0;
	endtask

	// strobes one read and waits until csr_rdata carries its data.
	task automatic read_reg(input logic [CSR_ADDR_W-1:0] addr);
		int waited;
		raw = '0;
		csr_rd = 1'b1;
		csr_addr = addr;
		tick();
		csr_rd = 1'b0;
		waited = 0;
		while (waited < READ_LATENCY && waited < READ_TIMEOUT)
		begin
			tick();
			waited++;
		end
		if (waited >= READ_TIMEOUT)
		begin
			errors++;
			$display("read of address 0x%h returned no data in %0d cycles", addr, waited);
		end
	endtask

	task automatic verify_read(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] expected);
		logic [CSR_DATA_W-1:0] model_value;
		read_reg(addr);
		model_value = model_read(addr);
		if (addr == CSR_ADDR_ENABLE)
		begin
			check_mask("csr_rdata mask", perf_group_en_t'(csr_rdata[4:0]),
				perf_group_en_t'(expected[4:0]));
			check_count("csr_rdata above mask",
				COUNT_WIDTH'(csr_rdata >> $bits(perf_group_en_t)), '0);
			check_mask("model mask", model_mask, perf_group_en_t'(expected[4:0]));
		end
		else
		begin
			check_count($sformatf("csr_rdata at 0x%h", addr), csr_rdata, expected);
			check_count($sformatf("model at 0x%h", addr), model_value, expected);
		end
	endtask

	task automatic run_random(input int cycles);
		logic [$bits(perf_raw_t)-1:0] bits;
		for (int n = 0; n < cycles; n++)
		begin
			for (int k = 0; k < $bits(perf_raw_t); k++)
			begin
				lfsr_state = lfsr_step(lfsr_state);
				bits[k] = lfsr_state[0];
			end
			raw = perf_raw_t'(bits);
			tick();
		end
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("simulation stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		int idx;
		int test_start_errors;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		reset = 1'b1;
		raw = '0;
		csr_wr = 1'b0;
		csr_rd = 1'b0;
		csr_addr = '0;
		csr_wdata = '0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		test_start_errors = 0;
		lfsr_state = 32'h8754;
		for (int i = 0; i < NUM_COUNTERS; i++)
			model_counts[i] = '0;
		model_mask = '1;
		model_raw_q = '0;
		model_flush_prev = 1'b0;
		model_ev = '0;
		model_clear = 1'b0;
		for (int i = 0; i < STIM_DEPTH; i++)
			stim_mem[i] = '0;
		$readmemh("tb/perf_stim.txt", stim_mem);
		if (stim_mem[0] == 0)
		begin
			errors++;
			$display("stimulus file is missing or empty");
		end
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		check_count("csr_rdata after reset", csr_rdata, '0);

		idx = 0;
		while (idx + 2 < STIM_DEPTH && stim_mem[idx] != 0)
		begin
			op = stim_mem[idx];
			a = stim_mem[idx+1];
			b = stim_mem[idx+2];
			case (op)
				1:
				begin
					raw = perf_raw_t'(a[$bits(perf_raw_t)-1:0]);
					repeat (int'(b)) tick();
				end
				2: write_reg(a[CSR_ADDR_W-1:0], b);
				3: verify_read(a[CSR_ADDR_W-1:0], b);
				4:
				begin
					raw = '0;
					repeat (int'(b)) tick();
				end
				5: run_random(int'(b));
				6:
				begin
					for (int i = 0; i < NUM_COUNTERS; i++)
					begin
						read_reg(CSR_ADDR_W'(i));
						check_count($sformatf("csr_rdata at 0x%h", CSR_ADDR_W'(i)), csr_rdata,
							COUNT_WIDTH'(model_read(CSR_ADDR_W'(i))));
					end
				end
				7:
				begin
					tests_run++;
					$display("test %0d done: %0d errors", a, errors - test_start_errors);
					test_start_errors = errors;
				end
				default:
				begin
					errors++;
					$display("unknown stimulus command %0h at word %0d", op, idx);
				end
			endcase
			idx += 3;
		end

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule : perf_monitor_tb

`default_nettype wire

//--- tb/perf_stim.txt
// three hex words per command: op a b. op 1 raw=a for b cycles, 2 write addr a data b,
// 3 read addr a expect b, 4 idle b cycles, 5 lfsr raw for b cycles, 6 all counters
// against the model, 7 end of test a, 0 stop.
// test 1: reset values.
3 c 1f
6 0 0
7 1 0
// test 2: qualifiers, stalled strobes ignored, held flush counted once per edge.
1 0800 3
1 4ac0 2
1 1000 3
1 0000 1
1 1000 1
1 0200 2
1 0080 1
1 0040 1
1 0010 2
1 2010 1
1 2008 1
1 0006 1
1 0005 1
1 0004 1
4 0 4
3 0 2
3 1 3
3 3 2
3 5 2
3 7 2
3 8 2
7 2 0
// test 3: miss wrap, l2 takes one extra miss.
1 0400 4
1 0100 4
1 0020 4
4 0 4
3 2 1
3 4 1
3 6 4
1 0020 1
4 0 4
3 6 1
7 3 0
// test 4: l1i group off while l1d counts.
2 c 17
1 0680 3
4 0 4
3 2 1
3 3 2
3 5 5
3 c 17
2 c 1f
7 4 0
// test 5: clear with an event landing in the same cycle, unmapped reads.
1 0800 2
2 d 0
4 0 4
3 0 0
3 1 0
3 9 0
3 d 0
7 5 0
// test 6: random raw vectors.
5 0 c8
4 0 4
6 0 0
7 6 0
0 0 0

//--- compile.f
src/perf_pkg.sv
src/perf_event_decode.sv
src/perf_counter_bank.sv
src/perf_csr_block.sv
src/perf_monitor_top.sv
tb/perf_monitor_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the performance monitor testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=perf_monitor_sim

verilator --binary --timing -f compile.f --top-module perf_monitor_tb \
	-Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
